// File: axi_tap_pkg.sv
`default_nettype none

package axi_tap_pkg;

  // AXI write-path field types
  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  strb_t;
  typedef logic [3:0]  id_t;
  typedef logic [7:0]  len_t;
  typedef logic [1:0]  resp_t;

  // stream side-band carries awlen, wstrb or bresp, zero-extended
  typedef logic [7:0]  tuser_t;

  // channel codes on the stream destination field
  // numbering kept compatible with the older five-channel tap
  typedef enum logic [2:0] {
    CHAN_AW = 3'd1,
    CHAN_W  = 3'd3,
    CHAN_B  = 3'd4
  } chan_t;

  // records buffered per channel before the arbiter
  localparam int DEFAULT_FIFO_DEPTH = 4;

endpackage

`default_nettype wire

// File: axi_tap_top.sv
`default_nettype none

module axi_tap_top #(
  parameter int FIFO_DEPTH = axi_tap_pkg::DEFAULT_FIFO_DEPTH
) (
  input  wire                     clk,
  input  wire                     resetn,
  // manager side
  input  wire axi_tap_pkg::id_t   s_awid,
  input  wire axi_tap_pkg::addr_t s_awaddr,
  input  wire axi_tap_pkg::len_t  s_awlen,
  input  wire                     s_awvalid,
  output logic                    s_awready,
  input  wire axi_tap_pkg::id_t   s_wid,
  input  wire axi_tap_pkg::data_t s_wdata,
  input  wire axi_tap_pkg::strb_t s_wstrb,
  input  wire                     s_wlast,
  input  wire                     s_wvalid,
  output logic                    s_wready,
  output axi_tap_pkg::id_t        s_bid,
  output axi_tap_pkg::resp_t      s_bresp,
  output logic                    s_bvalid,
  input  wire                     s_bready,
  // subordinate side
  output axi_tap_pkg::id_t        m_awid,
  output axi_tap_pkg::addr_t      m_awaddr,
  output axi_tap_pkg::len_t       m_awlen,
  output logic                    m_awvalid,
  input  wire                     m_awready,
  output axi_tap_pkg::id_t        m_wid,
  output axi_tap_pkg::data_t      m_wdata,
  output axi_tap_pkg::strb_t      m_wstrb,
  output logic                    m_wlast,
  output logic                    m_wvalid,
  input  wire                     m_wready,
  input  wire axi_tap_pkg::id_t   m_bid,
  input  wire axi_tap_pkg::resp_t m_bresp,
  input  wire                     m_bvalid,
  output logic                    m_bready,
  // captured handshakes
  output logic                    stream_tvalid,
  input  wire                     stream_tready,
  output axi_tap_pkg::data_t      stream_tdata,
  output axi_tap_pkg::id_t        stream_tid,
  output axi_tap_pkg::chan_t      stream_tdest,
  output axi_tap_pkg::tuser_t     stream_tuser,
  output logic                    stream_tlast
);

  logic                aw_rec_valid;
  logic                aw_rec_pop;
  axi_tap_pkg::data_t  aw_rec_data;
  axi_tap_pkg::id_t    aw_rec_id;
  axi_tap_pkg::tuser_t aw_rec_user;
  logic                aw_rec_last;
  axi_tap_pkg::chan_t  aw_rec_dest;

  logic                w_rec_valid;
  logic                w_rec_pop;
  axi_tap_pkg::data_t  w_rec_data;
  axi_tap_pkg::id_t    w_rec_id;
  axi_tap_pkg::tuser_t w_rec_user;
  logic                w_rec_last;
  axi_tap_pkg::chan_t  w_rec_dest;

  logic                b_rec_valid;
  logic                b_rec_pop;
  axi_tap_pkg::data_t  b_rec_data;
  axi_tap_pkg::id_t    b_rec_id;
  axi_tap_pkg::tuser_t b_rec_user;
  logic                b_rec_last;
  axi_tap_pkg::chan_t  b_rec_dest;

  tap_aw #(.FIFO_DEPTH(FIFO_DEPTH)) tap_aw_i (
    .clk(clk), .resetn(resetn),
    .s_awid(s_awid), .s_awaddr(s_awaddr), .s_awlen(s_awlen),
    .s_awvalid(s_awvalid), .s_awready(s_awready),
    .m_awid(m_awid), .m_awaddr(m_awaddr), .m_awlen(m_awlen),
    .m_awvalid(m_awvalid), .m_awready(m_awready),
    .rec_pop(aw_rec_pop), .rec_valid(aw_rec_valid), .rec_data(aw_rec_data),
    .rec_id(aw_rec_id), .rec_user(aw_rec_user), .rec_last(aw_rec_last),
    .rec_dest(aw_rec_dest)
  );

  tap_w #(.FIFO_DEPTH(FIFO_DEPTH)) tap_w_i (
    .clk(clk), .resetn(resetn),
    .s_wid(s_wid), .s_wdata(s_wdata), .s_wstrb(s_wstrb), .s_wlast(s_wlast),
    .s_wvalid(s_wvalid), .s_wready(s_wready),
    .m_wid(m_wid), .m_wdata(m_wdata), .m_wstrb(m_wstrb), .m_wlast(m_wlast),
    .m_wvalid(m_wvalid), .m_wready(m_wready),
    .rec_pop(w_rec_pop), .rec_valid(w_rec_valid), .rec_data(w_rec_data),
    .rec_id(w_rec_id), .rec_user(w_rec_user), .rec_last(w_rec_last),
    .rec_dest(w_rec_dest)
  );

  tap_b #(.FIFO_DEPTH(FIFO_DEPTH)) tap_b_i (
    .clk(clk), .resetn(resetn),
    .m_bid(m_bid), .m_bresp(m_bresp), .m_bvalid(m_bvalid), .m_bready(m_bready),
    .s_bid(s_bid), .s_bresp(s_bresp), .s_bvalid(s_bvalid), .s_bready(s_bready),
    .rec_pop(b_rec_pop), .rec_valid(b_rec_valid), .rec_data(b_rec_data),
    .rec_id(b_rec_id), .rec_user(b_rec_user), .rec_last(b_rec_last),
    .rec_dest(b_rec_dest)
  );

  tap_stream_arbiter arbiter_i (
    .clk(clk), .resetn(resetn),
    .aw_rec_valid(aw_rec_valid), .aw_rec_data(aw_rec_data), .aw_rec_id(aw_rec_id),
    .aw_rec_user(aw_rec_user), .aw_rec_last(aw_rec_last), .aw_rec_dest(aw_rec_dest),
    .w_rec_valid(w_rec_valid), .w_rec_data(w_rec_data), .w_rec_id(w_rec_id),
    .w_rec_user(w_rec_user), .w_rec_last(w_rec_last), .w_rec_dest(w_rec_dest),
    .b_rec_valid(b_rec_valid), .b_rec_data(b_rec_data), .b_rec_id(b_rec_id),
    .b_rec_user(b_rec_user), .b_rec_last(b_rec_last), .b_rec_dest(b_rec_dest),
    .aw_rec_pop(aw_rec_pop), .w_rec_pop(w_rec_pop), .b_rec_pop(b_rec_pop),
    .stream_tvalid(stream_tvalid), .stream_tready(stream_tready),
    .stream_tdata(stream_tdata), .stream_tid(stream_tid),
    .stream_tdest(stream_tdest), .stream_tuser(stream_tuser),
    .stream_tlast(stream_tlast)
  );

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_axi_tap -f sim.f -o tb_axi_tap_sim

out=$(./obj_dir/tb_axi_tap_sim)
echo "$out"

if echo "$out" | grep -qx "PASS: all tests"; then
  exit 0
fi
exit 1

// File: sim.f
axi_tap_pkg.sv
tap_record_fifo.sv
tap_aw.sv
tap_w.sv
tap_b.sv
tap_stream_arbiter.sv
axi_tap_top.sv
tb_clock_gen.sv
tb_axi_tap.sv

// File: tap_aw.sv
`default_nettype none

module tap_aw #(
  parameter int FIFO_DEPTH = axi_tap_pkg::DEFAULT_FIFO_DEPTH
) (
  input  wire                     clk,
  input  wire                     resetn,
  input  wire axi_tap_pkg::id_t   s_awid,
  input  wire axi_tap_pkg::addr_t s_awaddr,
  input  wire axi_tap_pkg::len_t  s_awlen,
  input  wire                     s_awvalid,
  input  wire                     m_awready,
  input  wire                     rec_pop,
  output logic                    s_awready,
  output axi_tap_pkg::id_t        m_awid,
  output axi_tap_pkg::addr_t      m_awaddr,
  output axi_tap_pkg::len_t       m_awlen,
  output logic                    m_awvalid,
  output logic                    rec_valid,
  output axi_tap_pkg::data_t      rec_data,
  output axi_tap_pkg::id_t        rec_id,
  output axi_tap_pkg::tuser_t     rec_user,
  output logic                    rec_last,
  output axi_tap_pkg::chan_t      rec_dest
);

  logic fifo_full;

  // the address phase only proceeds while there is room for its record
  assign m_awvalid = s_awvalid && !fifo_full;
  assign s_awready = m_awready && !fifo_full;
  assign m_awid    = s_awid;
  assign m_awaddr  = s_awaddr;
  assign m_awlen   = s_awlen;

  // an address record is always a single beat
  tap_record_fifo #(
    .FIFO_DEPTH(FIFO_DEPTH)
  ) rec_fifo_i (
    .clk(clk),
    .resetn(resetn),
    .push(s_awvalid && m_awready),
    .pop(rec_pop),
    .in_data(s_awaddr),
    .in_id(s_awid),
    .in_user(s_awlen),
    .in_last(1'b1),
    .full(fifo_full),
    .not_empty(rec_valid),
    .out_data(rec_data),
    .out_id(rec_id),
    .out_user(rec_user),
    .out_last(rec_last)
  );

  assign rec_dest = axi_tap_pkg::CHAN_AW;

endmodule

`default_nettype wire

// File: tap_b.sv
`default_nettype none

module tap_b #(
  parameter int FIFO_DEPTH = axi_tap_pkg::DEFAULT_FIFO_DEPTH
) (
  input  wire                     clk,
  input  wire                     resetn,
  input  wire axi_tap_pkg::id_t   m_bid,
  input  wire axi_tap_pkg::resp_t m_bresp,
  input  wire                     m_bvalid,
  input  wire                     s_bready,
  input  wire                     rec_pop,
  output logic                    m_bready,
  output axi_tap_pkg::id_t        s_bid,
  output axi_tap_pkg::resp_t      s_bresp,
  output logic                    s_bvalid,
  output logic                    rec_valid,
  output axi_tap_pkg::data_t      rec_data,
  output axi_tap_pkg::id_t        rec_id,
  output axi_tap_pkg::tuser_t     rec_user,
  output logic                    rec_last,
  output axi_tap_pkg::chan_t      rec_dest
);

  logic fifo_full;

  // responses run from the subordinate back toward the manager
  assign s_bvalid = m_bvalid && !fifo_full;
  assign m_bready = s_bready && !fifo_full;
  assign s_bid    = m_bid;
  assign s_bresp  = m_bresp;

  // a response has no payload, only id and resp are of interest
  tap_record_fifo #(
    .FIFO_DEPTH(FIFO_DEPTH)
  ) rec_fifo_i (
    .clk(clk),
    .resetn(resetn),
    .push(m_bvalid && s_bready),
    .pop(rec_pop),
    .in_data('0),
    .in_id(m_bid),
    .in_user(axi_tap_pkg::tuser_t'(m_bresp)),
    .in_last(1'b1),
    .full(fifo_full),
    .not_empty(rec_valid),
    .out_data(rec_data),
    .out_id(rec_id),
    .out_user(rec_user),
    .out_last(rec_last)
  );

  assign rec_dest = axi_tap_pkg::CHAN_B;

endmodule

`default_nettype wire

// File: tap_record_fifo.sv
`default_nettype none

module tap_record_fifo #(
  parameter int FIFO_DEPTH = axi_tap_pkg::DEFAULT_FIFO_DEPTH
) (
  input  wire                  clk,
  input  wire                  resetn,
  input  wire                  push,
  input  wire                  pop,
  input  wire axi_tap_pkg::data_t  in_data,
  input  wire axi_tap_pkg::id_t    in_id,
  input  wire axi_tap_pkg::tuser_t in_user,
  input  wire                  in_last,
  output logic                 full,
  output logic                 not_empty,
  output axi_tap_pkg::data_t   out_data,
  output axi_tap_pkg::id_t     out_id,
  output axi_tap_pkg::tuser_t  out_user,
  output logic                 out_last
);

  localparam int PTR_W = $clog2(FIFO_DEPTH);

  axi_tap_pkg::data_t  data_mem [FIFO_DEPTH];
  axi_tap_pkg::id_t    id_mem   [FIFO_DEPTH];
  axi_tap_pkg::tuser_t user_mem [FIFO_DEPTH];
  logic                last_mem [FIFO_DEPTH];

  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W:0]   count;
  logic             do_push;
  logic             do_pop;

  assign full      = (count == (PTR_W + 1)'(FIFO_DEPTH));
  assign not_empty = (count != '0);

  // requests that cannot be served are dropped here
  assign do_push = push && !full;
  assign do_pop  = pop && not_empty;

  // pointers wrap on their own since the depth is a power of two
  always_ff @(posedge clk) begin
    if (resetn) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) begin
      data_mem[wr_ptr] <= in_data;
      id_mem[wr_ptr]   <= in_id;
      user_mem[wr_ptr] <= in_user;
      last_mem[wr_ptr] <= in_last;
    end
  end

  // head record is visible without a read cycle
  assign out_data = data_mem[rd_ptr];
  assign out_id   = id_mem[rd_ptr];
  assign out_user = user_mem[rd_ptr];
  assign out_last = last_mem[rd_ptr];

endmodule

`default_nettype wire

// File: tap_stream_arbiter.sv
`default_nettype none

module tap_stream_arbiter (
  input  wire                      clk,
  input  wire                      resetn,
  input  wire                      stream_tready,
  input  wire                      aw_rec_valid,
  input  wire axi_tap_pkg::data_t  aw_rec_data,
  input  wire axi_tap_pkg::id_t    aw_rec_id,
  input  wire axi_tap_pkg::tuser_t aw_rec_user,
  input  wire                      aw_rec_last,
  input  wire axi_tap_pkg::chan_t  aw_rec_dest,
  input  wire                      w_rec_valid,
  input  wire axi_tap_pkg::data_t  w_rec_data,
  input  wire axi_tap_pkg::id_t    w_rec_id,
  input  wire axi_tap_pkg::tuser_t w_rec_user,
  input  wire                      w_rec_last,
  input  wire axi_tap_pkg::chan_t  w_rec_dest,
  input  wire                      b_rec_valid,
  input  wire axi_tap_pkg::data_t  b_rec_data,
  input  wire axi_tap_pkg::id_t    b_rec_id,
  input  wire axi_tap_pkg::tuser_t b_rec_user,
  input  wire                      b_rec_last,
  input  wire axi_tap_pkg::chan_t  b_rec_dest,
  output logic                     aw_rec_pop,
  output logic                     w_rec_pop,
  output logic                     b_rec_pop,
  output logic                     stream_tvalid,
  output axi_tap_pkg::data_t       stream_tdata,
  output axi_tap_pkg::id_t         stream_tid,
  output axi_tap_pkg::chan_t       stream_tdest,
  output axi_tap_pkg::tuser_t      stream_tuser,
  output logic                     stream_tlast
);

  typedef logic [1:0] chan_idx_t;
  typedef enum logic {
    ARB_IDLE,
    ARB_BURST
  } arb_state_t;

  localparam chan_idx_t AW_IDX = 2'd0;
  localparam chan_idx_t W_IDX  = 2'd1;
  localparam chan_idx_t B_IDX  = 2'd2;

  arb_state_t          state;
  chan_idx_t           last_idx;
  chan_idx_t           cand_first;
  chan_idx_t           cand_second;
  chan_idx_t           grant_idx;
  logic                grant;
  logic                load_ok;
  logic [2:0]          valid_v;
  logic [2:0]          last_v;
  axi_tap_pkg::data_t  data_v [3];
  axi_tap_pkg::id_t    id_v   [3];
  axi_tap_pkg::tuser_t user_v [3];
  axi_tap_pkg::chan_t  dest_v [3];

  function automatic chan_idx_t next_chan(input chan_idx_t idx);
    return (idx == B_IDX) ? AW_IDX : idx + 2'd1;
  endfunction

  // channel order here sets the search order AW, W, B
  assign valid_v = {b_rec_valid, w_rec_valid, aw_rec_valid};
  assign last_v  = {b_rec_last, w_rec_last, aw_rec_last};
  assign data_v  = '{aw_rec_data, w_rec_data, b_rec_data};
  assign id_v    = '{aw_rec_id, w_rec_id, b_rec_id};
  assign user_v  = '{aw_rec_user, w_rec_user, b_rec_user};
  assign dest_v  = '{aw_rec_dest, w_rec_dest, b_rec_dest};

  // the output register takes a new beat when empty or draining this cycle
  assign load_ok = !stream_tvalid || stream_tready;

  assign cand_first  = next_chan(last_idx);
  assign cand_second = next_chan(cand_first);

  always_comb begin
    grant     = 1'b0;
    grant_idx = last_idx;
    if (load_ok) begin
      if (state == ARB_BURST) begin
        // an open W burst keeps the grant until its last beat
        grant = valid_v[last_idx];
      end else if (valid_v[cand_first]) begin
        grant     = 1'b1;
        grant_idx = cand_first;
      end else if (valid_v[cand_second]) begin
        grant     = 1'b1;
        grant_idx = cand_second;
      end else if (valid_v[last_idx]) begin
        grant = 1'b1;
      end
    end
  end

  assign aw_rec_pop = grant && (grant_idx == AW_IDX);
  assign w_rec_pop  = grant && (grant_idx == W_IDX);
  assign b_rec_pop  = grant && (grant_idx == B_IDX);

  // starting from B makes AW the first channel searched after reset
  always_ff @(posedge clk) begin
    if (resetn) begin
      state         <= ARB_IDLE;
      last_idx      <= B_IDX;
      stream_tvalid <= 1'b0;
    end else if (grant) begin
      state         <= last_v[grant_idx] ? ARB_IDLE : ARB_BURST;
      last_idx      <= grant_idx;
      stream_tvalid <= 1'b1;
    end else if (stream_tready) begin
      stream_tvalid <= 1'b0;
    end
  end

  // payload only moves on a grant, so it holds under back-pressure
  always_ff @(posedge clk) begin
    if (grant) begin
      stream_tdata <= data_v[grant_idx];
      stream_tid   <= id_v[grant_idx];
      stream_tuser <= user_v[grant_idx];
      stream_tlast <= last_v[grant_idx];
      stream_tdest <= dest_v[grant_idx];
    end
  end

endmodule

`default_nettype wire

// File: tap_w.sv
`default_nettype none

module tap_w #(
  parameter int FIFO_DEPTH = axi_tap_pkg::DEFAULT_FIFO_DEPTH
) (
  input  wire                     clk,
  input  wire                     resetn,
  input  wire axi_tap_pkg::id_t   s_wid,
  input  wire axi_tap_pkg::data_t s_wdata,
  input  wire axi_tap_pkg::strb_t s_wstrb,
  input  wire                     s_wlast,
  input  wire                     s_wvalid,
  input  wire                     m_wready,
  input  wire                     rec_pop,
  output logic                    s_wready,
  output axi_tap_pkg::id_t        m_wid,
  output axi_tap_pkg::data_t      m_wdata,
  output axi_tap_pkg::strb_t      m_wstrb,
  output logic                    m_wlast,
  output logic                    m_wvalid,
  output logic                    rec_valid,
  output axi_tap_pkg::data_t      rec_data,
  output axi_tap_pkg::id_t        rec_id,
  output axi_tap_pkg::tuser_t     rec_user,
  output logic                    rec_last,
  output axi_tap_pkg::chan_t      rec_dest
);

  logic fifo_full;

  assign m_wvalid = s_wvalid && !fifo_full;
  assign s_wready = m_wready && !fifo_full;
  assign m_wid    = s_wid;
  assign m_wdata  = s_wdata;
  assign m_wstrb  = s_wstrb;
  assign m_wlast  = s_wlast;

  // every beat is captured, wlast marks the end of the burst on the stream
  tap_record_fifo #(
    .FIFO_DEPTH(FIFO_DEPTH)
  ) rec_fifo_i (
    .clk(clk),
    .resetn(resetn),
    .push(s_wvalid && m_wready),
    .pop(rec_pop),
    .in_data(s_wdata),
    .in_id(s_wid),
    .in_user(axi_tap_pkg::tuser_t'(s_wstrb)),
    .in_last(s_wlast),
    .full(fifo_full),
    .not_empty(rec_valid),
    .out_data(rec_data),
    .out_id(rec_id),
    .out_user(rec_user),
    .out_last(rec_last)
  );

  assign rec_dest = axi_tap_pkg::CHAN_W;

endmodule

`default_nettype wire

// File: tb_axi_tap.sv
`default_nettype none

module tb_axi_tap;

  localparam int FIFO_DEPTH = 4;
  localparam int WAIT_LIMIT = 300;
  localparam logic [1:0] READY_HIGH   = 2'd0;
  localparam logic [1:0] READY_LOW    = 2'd1;
  localparam logic [1:0] READY_RANDOM = 2'd2;

  logic clk;
  logic resetn;
  axi_tap_pkg::id_t    s_awid;
  axi_tap_pkg::addr_t  s_awaddr;
  axi_tap_pkg::len_t   s_awlen;
  logic                s_awvalid;
  logic                s_awready;
  axi_tap_pkg::id_t    s_wid;
  axi_tap_pkg::data_t  s_wdata;
  axi_tap_pkg::strb_t  s_wstrb;
  logic                s_wlast;
  logic                s_wvalid;
  logic                s_wready;
  axi_tap_pkg::id_t    s_bid;
  axi_tap_pkg::resp_t  s_bresp;
  logic                s_bvalid;
  logic                s_bready = 1'b1;
  axi_tap_pkg::id_t    m_awid;
  axi_tap_pkg::addr_t  m_awaddr;
  axi_tap_pkg::len_t   m_awlen;
  logic                m_awvalid;
  logic                m_awready = 1'b1;
  axi_tap_pkg::id_t    m_wid;
  axi_tap_pkg::data_t  m_wdata;
  axi_tap_pkg::strb_t  m_wstrb;
  logic                m_wlast;
  logic                m_wvalid;
  logic                m_wready = 1'b1;
  axi_tap_pkg::id_t    m_bid;
  axi_tap_pkg::resp_t  m_bresp;
  logic                m_bvalid;
  logic                m_bready;
  logic                stream_tvalid;
  logic                stream_tready = 1'b1;
  axi_tap_pkg::data_t  stream_tdata;
  axi_tap_pkg::id_t    stream_tid;
  axi_tap_pkg::chan_t  stream_tdest;
  axi_tap_pkg::tuser_t stream_tuser;
  logic                stream_tlast;

  integer seed = 61684;
  int errors = 0;
  int beats = 0;
  logic timed_out = 1'b0;
  logic [1:0] ready_mode = READY_HIGH;
  logic w_open = 1'b0;
  logic rr_check = 1'b0;
  logic rr_have_prev = 1'b0;
  axi_tap_pkg::chan_t rr_prev;
  logic prev_stall = 1'b0;
  logic [47:0] prev_beat;

  // expected records per channel as {data, id, user, last}
  logic [44:0] aw_q[$];
  logic [44:0] w_q[$];
  logic [44:0] b_q[$];

  tb_clock_gen #(.PERIOD(40)) clock_gen_i (.clk(clk));

  axi_tap_top #(.FIFO_DEPTH(FIFO_DEPTH)) axi_tap_top_i (.*);

  task automatic flag_mismatch(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
    errors++;
    $display("ERR t=%0t %s got=%h exp=%h", $time, name, got, exp);
  endtask

  task automatic flag_problem(input string msg);
    errors++;
    $display("t=%0t: %s", $time, msg);
  endtask

  function automatic axi_tap_pkg::chan_t next_in_cycle(input axi_tap_pkg::chan_t c);
    case (c)
      axi_tap_pkg::CHAN_AW: return axi_tap_pkg::CHAN_W;
      axi_tap_pkg::CHAN_W:  return axi_tap_pkg::CHAN_B;
      default:              return axi_tap_pkg::CHAN_AW;
    endcase
  endfunction

  // a handshaken record waits in its FIFO until it reaches the output register
  function automatic int fifo_fill(input int queued, input axi_tap_pkg::chan_t chan);
    return queued - ((stream_tvalid && stream_tdest == chan) ? 1 : 0);
  endfunction

  function automatic logic ready_of(input int chan);
    case (chan)
      0:       return s_awready;
      1:       return s_wready;
      default: return m_bready;
    endcase
  endfunction

  // returns just after the edge on which the source handshake completes
  task automatic await_ready(input int chan, input string what);
    int n;
    n = 0;
    @(negedge clk);
    while (!ready_of(chan) && !timed_out) begin
      n++;
      if (n > WAIT_LIMIT) begin
        flag_problem({what, " handshake never completed"});
        timed_out = 1'b1;
      end
      @(negedge clk);
    end
    @(posedge clk);
  endtask

  task automatic send_aw(input axi_tap_pkg::id_t id, input axi_tap_pkg::addr_t addr,
                         input axi_tap_pkg::len_t len);
    s_awid    <= id;
    s_awaddr  <= addr;
    s_awlen   <= len;
    s_awvalid <= 1'b1;
    await_ready(0, "AW");
    s_awvalid <= 1'b0;
  endtask

  task automatic send_w_burst(input axi_tap_pkg::id_t id, input int count);
    for (int k = 0; k < count; k++) begin
      s_wid    <= id;
      s_wdata  <= $random(seed);
      s_wstrb  <= 4'($random(seed));
      s_wlast  <= (k == count - 1);
      s_wvalid <= 1'b1;
      await_ready(1, "W");
    end
    s_wvalid <= 1'b0;
  endtask

  task automatic send_b(input axi_tap_pkg::id_t id, input axi_tap_pkg::resp_t resp);
    m_bid    <= id;
    m_bresp  <= resp;
    m_bvalid <= 1'b1;
    await_ready(2, "B");
    m_bvalid <= 1'b0;
  endtask

  task automatic wait_stream_valid();
    int n;
    n = 0;
    @(negedge clk);
    while (!stream_tvalid && !timed_out) begin
      n++;
      if (n > WAIT_LIMIT) begin
        flag_problem("stream_tvalid never rose");
        timed_out = 1'b1;
      end
      @(negedge clk);
    end
    @(posedge clk);
  endtask

  // the queues only change at the falling edge, so they are read at the rising one
  task automatic wait_drain();
    int n;
    n = 0;
    @(posedge clk);
    while ((aw_q.size() + w_q.size() + b_q.size()) != 0 && !timed_out) begin
      n++;
      if (n > WAIT_LIMIT) begin
        flag_problem("predicted records did not all reach the stream");
        timed_out = 1'b1;
      end
      @(posedge clk);
    end
  endtask

  // a full record FIFO holds back both the sink valid and the source ready
  task automatic check_pass_through(input string name, input logic full, src_valid,
                                    src_ready, snk_valid, snk_ready,
                                    input logic [63:0] src_pay, snk_pay);
    assert (snk_pay == src_pay) else flag_mismatch({name, " payload"}, snk_pay, src_pay);
    assert (snk_valid == (src_valid && !full))
      else flag_mismatch({name, " sink valid"}, 64'(snk_valid), 64'(src_valid && !full));
    assert (src_ready == (snk_ready && !full))
      else flag_mismatch({name, " source ready"}, 64'(src_ready), 64'(snk_ready && !full));
  endtask

  task automatic check_beat();
    logic [44:0] got;
    logic [44:0] exp;
    logic        have;
    got  = {stream_tdata, stream_tid, stream_tuser, stream_tlast};
    exp  = '0;
    have = 1'b1;
    beats++;
    if (w_open) begin
      assert (stream_tdest == axi_tap_pkg::CHAN_W)
        else flag_problem("a beat from another channel broke into an open W burst");
    end
    if (rr_check && rr_have_prev) begin
      assert (stream_tdest == next_in_cycle(rr_prev))
        else flag_mismatch("stream_tdest", 64'(stream_tdest), 64'(next_in_cycle(rr_prev)));
    end
    rr_prev      = stream_tdest;
    rr_have_prev = 1'b1;
    case (stream_tdest)
      axi_tap_pkg::CHAN_AW: begin
        if (aw_q.size() > 0) begin
          exp = aw_q.pop_front();
        end else begin
          have = 1'b0;
        end
      end
      axi_tap_pkg::CHAN_W: begin
        w_open = !stream_tlast;
        if (w_q.size() > 0) begin
          exp = w_q.pop_front();
        end else begin
          have = 1'b0;
        end
      end
      axi_tap_pkg::CHAN_B: begin
        if (b_q.size() > 0) begin
          exp = b_q.pop_front();
        end else begin
          have = 1'b0;
        end
      end
      default: begin
        flag_problem("stream beat carries an unknown tdest");
        return;
      end
    endcase
    if (have) begin
      assert (got == exp) else flag_mismatch("stream record", 64'(got), 64'(exp));
    end else begin
      flag_problem("stream beat without a matching handshake");
    end
  endtask

  // all values are settled at the falling edge, half a cycle after the drive
  always @(negedge clk) begin
    logic [47:0] cur_beat;
    logic        aw_full;
    logic        w_full;
    logic        b_full;
    if (!resetn) begin
      aw_full = fifo_fill(aw_q.size(), axi_tap_pkg::CHAN_AW) == FIFO_DEPTH;
      w_full  = fifo_fill(w_q.size(), axi_tap_pkg::CHAN_W) == FIFO_DEPTH;
      b_full  = fifo_fill(b_q.size(), axi_tap_pkg::CHAN_B) == FIFO_DEPTH;
      check_pass_through("aw", aw_full, s_awvalid, s_awready, m_awvalid, m_awready,
                         64'({s_awid, s_awaddr, s_awlen}), 64'({m_awid, m_awaddr, m_awlen}));
      check_pass_through("w", w_full, s_wvalid, s_wready, m_wvalid, m_wready,
                         64'({s_wid, s_wdata, s_wstrb, s_wlast}),
                         64'({m_wid, m_wdata, m_wstrb, m_wlast}));
      check_pass_through("b", b_full, m_bvalid, m_bready, s_bvalid, s_bready,
                         64'({m_bid, m_bresp}), 64'({s_bid, s_bresp}));
      cur_beat = {stream_tdata, stream_tid, stream_tdest, stream_tuser, stream_tlast};
      if (prev_stall) begin
        assert (stream_tvalid) else flag_problem("stream_tvalid dropped without a transfer");
        assert (cur_beat == prev_beat)
          else flag_mismatch("stream payload", 64'(cur_beat), 64'(prev_beat));
      end
      prev_stall = stream_tvalid && !stream_tready;
      prev_beat  = cur_beat;
      if (stream_tvalid && stream_tready) begin
        check_beat();
      end
      if (s_awvalid && s_awready) begin
        aw_q.push_back({s_awaddr, s_awid, s_awlen, 1'b1});
      end
      if (s_wvalid && s_wready) begin
        w_q.push_back({s_wdata, s_wid, 4'h0, s_wstrb, s_wlast});
      end
      if (m_bvalid && m_bready) begin
        b_q.push_back({32'h0, m_bid, 6'h0, m_bresp, 1'b1});
      end
    end
  end

  // subordinate and stream readies, one driver for all of them
  always @(posedge clk) begin
    case (ready_mode)
      READY_RANDOM: begin
        stream_tready <= 1'($random(seed));
        m_awready     <= 1'($random(seed));
        m_wready      <= 1'($random(seed));
        s_bready      <= 1'($random(seed));
      end
      READY_LOW: begin
        stream_tready <= 1'b0;
        m_awready     <= 1'b1;
        m_wready      <= 1'b1;
        s_bready      <= 1'b1;
      end
      default: begin
        stream_tready <= 1'b1;
        m_awready     <= 1'b1;
        m_wready      <= 1'b1;
        s_bready      <= 1'b1;
      end
    endcase
  end

  initial begin
    int count;
    int stalls;
    resetn    = 1'b1;
    s_awid    = '0;
    s_awaddr  = '0;
    s_awlen   = '0;
    s_awvalid = 1'b0;
    s_wid     = '0;
    s_wdata   = '0;
    s_wstrb   = '0;
    s_wlast   = 1'b0;
    s_wvalid  = 1'b0;
    m_bid     = '0;
    m_bresp   = '0;
    m_bvalid  = 1'b0;
    repeat (8) @(posedge clk);
    resetn <= 1'b0;
    @(posedge clk);

    // mixed traffic with random back-pressure on every ready
    ready_mode <= READY_RANDOM;
    fork
      repeat (6) send_aw(4'($random(seed)), $random(seed), 8'($random(seed)));
      for (int b = 1; b <= 4; b++) begin
        send_w_burst(4'($random(seed)), b);
      end
      repeat (6) send_b(4'($random(seed)), 2'($random(seed)));
    join
    ready_mode <= READY_HIGH;
    wait_drain();

    // a B record fills the output register, then the AW FIFO has to fill up
    ready_mode <= READY_LOW;
    repeat (2) @(posedge clk);
    send_b(4'h5, 2'b10);
    wait_stream_valid();
    count  = 0;
    stalls = 0;
    s_awid    <= 4'($random(seed));
    s_awaddr  <= $random(seed);
    s_awlen   <= 8'($random(seed));
    s_awvalid <= 1'b1;
    while (stalls < 4 && !timed_out) begin
      @(negedge clk);
      if (s_awready) begin
        count++;
        stalls = 0;
      end else begin
        stalls++;
      end
      if (count > WAIT_LIMIT) begin
        flag_problem("AW never stalled under stream back-pressure");
        timed_out = 1'b1;
      end
      @(posedge clk);
      if (stalls == 0) begin
        s_awid   <= 4'($random(seed));
        s_awaddr <= $random(seed);
        s_awlen  <= 8'($random(seed));
      end
    end
    assert (count > 0 && count <= FIFO_DEPTH)
      else flag_mismatch("aw handshakes under back-pressure", 64'(count), 64'(FIFO_DEPTH));
    s_awvalid  <= 1'b0;
    ready_mode <= READY_HIGH;
    wait_drain();

    // two single-beat records pending on each channel, then grants rotate
    ready_mode <= READY_LOW;
    repeat (2) @(posedge clk);
    repeat (2) begin
      fork
        send_aw(4'($random(seed)), $random(seed), 8'($random(seed)));
        send_w_burst(4'($random(seed)), 1);
        send_b(4'($random(seed)), 2'($random(seed)));
      join
    end
    repeat (2) @(posedge clk);
    rr_check     = 1'b1;
    rr_have_prev = 1'b0;
    ready_mode <= READY_HIGH;
    wait_drain();
    rr_check = 1'b0;

    repeat (4) @(posedge clk);
    if ((aw_q.size() + w_q.size() + b_q.size()) != 0) begin
      flag_problem("some handshakes never showed up on the stream");
    end
    $display("done: %0d stream beats checked, %0d errors", beats, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD = 40
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

endmodule

`default_nettype wire
